/* design/luma_cost_pkg.sv */
// Luma cost engine shared definitions
// Widths, AXI4-Lite register map and the enums used across the design

package luma_cost_pkg;

    localparam int coef_width = 16;
    localparam int cost_width = 40;
    localparam int block_size = 16;
    localparam int addr_width = 12;
    localparam int data_width = 32;

    // Register byte offsets
    localparam logic [addr_width-1:0] reg_ctrl    = 12'h000;
    localparam logic [addr_width-1:0] reg_status  = 12'h004;
    localparam logic [addr_width-1:0] reg_cost_lo = 12'h008;
    localparam logic [addr_width-1:0] reg_cost_hi = 12'h00C;

    // Coefficient window, two coefficients per word
    localparam logic [addr_width-1:0] coef_base  = 12'h400;
    localparam int                    coef_words = 128;

    typedef enum logic {
        op_sse_all = 1'b0,
        op_sse_ac  = 1'b1
    } cost_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain,
        st_done
    } ctrl_state_e;

endpackage

/* design/axil_cost_regs.sv */
// AXI4-Lite slave for the luma cost engine
// Decodes the register map, fills the coefficient buffer and reports status and cost

`timescale 1ns/1ps

module axil_cost_regs (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       awvalid,
    output logic                                       awready,
    input  logic [luma_cost_pkg::addr_width-1:0]       awaddr,
    input  logic                                       wvalid,
    output logic                                       wready,
    input  logic [luma_cost_pkg::data_width-1:0]       wdata,
    output logic                                       bvalid,
    input  logic                                       bready,
    output logic [1:0]                                 bresp,
    input  logic                                       arvalid,
    output logic                                       arready,
    input  logic [luma_cost_pkg::addr_width-1:0]       araddr,
    output logic                                       rvalid,
    input  logic                                       rready,
    output logic [luma_cost_pkg::data_width-1:0]       rdata,
    output logic [1:0]                                 rresp,
    output logic                                       buf_we,
    output logic [$clog2(luma_cost_pkg::coef_words)-1:0] buf_waddr,
    output logic [luma_cost_pkg::data_width-1:0]       buf_wdata,
    output logic                                       cmd_start,
    output luma_cost_pkg::cost_op_e                    cmd_op,
    input  logic                                       busy,
    input  logic                                       done_flag,
    input  logic [luma_cost_pkg::cost_width-1:0]       cost,
    input  logic                                       cost_valid
);

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;
    localparam logic [luma_cost_pkg::addr_width-1:0] coef_end =
        luma_cost_pkg::coef_base + 12'(4 * luma_cost_pkg::coef_words);

    logic                                 wr_rdy;
    logic                                 wr_fire;
    logic                                 wr_ctrl;
    logic                                 wr_coef;
    logic                                 wr_err;
    logic                                 rd_rdy_q;
    logic                                 rd_fire;
    logic                                 rd_err;
    logic [luma_cost_pkg::data_width-1:0] rd_word;
    logic                                 done_q;
    logic                                 done_sticky;
    logic [luma_cost_pkg::cost_width-1:0] cost_q;

    // ----------------------------------------
    // Write decode
    // ----------------------------------------
    assign awready = wr_rdy;
    assign wready  = wr_rdy;
    assign wr_fire = awvalid && wvalid && wr_rdy;
    assign wr_ctrl = (awaddr == luma_cost_pkg::reg_ctrl);
    assign wr_coef = (awaddr >= luma_cost_pkg::coef_base) && (awaddr < coef_end);

    // Status and cost offsets take writes silently
    assign wr_err = (busy && wr_coef) || (busy && wr_ctrl && wdata[0]) ||
                    !(wr_ctrl || wr_coef || awaddr == luma_cost_pkg::reg_status ||
                      awaddr == luma_cost_pkg::reg_cost_lo ||
                      awaddr == luma_cost_pkg::reg_cost_hi);

    assign buf_we    = wr_fire && wr_coef && !busy;
    assign buf_waddr = awaddr[2 +: $clog2(luma_cost_pkg::coef_words)];
    assign buf_wdata = wdata;
    assign cmd_start = wr_fire && wr_ctrl && wdata[0] && !busy;
    assign cmd_op    = luma_cost_pkg::cost_op_e'(wdata[1]);

    // ----------------------------------------
    // Read decode
    // ----------------------------------------
    assign arready = !rvalid && arvalid && rd_rdy_q;
    assign rd_fire = arvalid && arready;

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (araddr)
            luma_cost_pkg::reg_ctrl:    rd_word = '0;
            luma_cost_pkg::reg_status:  rd_word[1:0] = {done_sticky, busy};
            luma_cost_pkg::reg_cost_lo: rd_word = cost_q[31:0];
            luma_cost_pkg::reg_cost_hi:
                rd_word = luma_cost_pkg::data_width'(cost_q[luma_cost_pkg::cost_width-1:32]);
            // Coefficient window is write-only
            default:                    rd_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_rdy   <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= resp_okay;
            rd_rdy_q <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= resp_okay;
        end else begin
            // One-cycle ready, only with both address and data present
            wr_rdy <= awvalid && wvalid && !wr_rdy && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_err ? resp_slverr : resp_okay;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            rd_rdy_q <= arvalid && !rd_rdy_q && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rdata  <= rd_word;
                rresp  <= rd_err ? resp_slverr : resp_okay;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Sticky done and last finished cost
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q      <= 1'b0;
            done_sticky <= 1'b0;
            cost_q      <= '0;
        end else begin
            done_q <= done_flag;
            if (done_flag && !done_q) begin
                done_sticky <= 1'b1;
            end else if (rd_fire && araddr == luma_cost_pkg::reg_status) begin
                done_sticky <= 1'b0;
            end
            if (cost_valid) begin
                cost_q <= cost;
            end
        end
    end

endmodule

/* design/coef_row_buf.sv */
// Coefficient block buffer
// Word-pair writes from the host side, one full row read per cycle

`timescale 1ns/1ps

module coef_row_buf #(
    parameter int COEF_WIDTH = luma_cost_pkg::coef_width,
    parameter int BLOCK_SIZE = luma_cost_pkg::block_size
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         we,
    input  logic [$clog2(luma_cost_pkg::coef_words)-1:0] waddr,
    input  logic [luma_cost_pkg::data_width-1:0]         wdata,
    input  logic [$clog2(BLOCK_SIZE)-1:0]                raddr,
    output logic [BLOCK_SIZE*COEF_WIDTH-1:0]             row_data
);

    localparam int PAIRS = BLOCK_SIZE / 2;
    localparam int PAIR_W = 2 * COEF_WIDTH;

    logic [BLOCK_SIZE*COEF_WIDTH-1:0] rows [BLOCK_SIZE];

    // Words past the block end are ignored for small blocks
    always_ff @(posedge clk) begin
        if (we && waddr < BLOCK_SIZE * PAIRS) begin
            rows[waddr / PAIRS][(waddr % PAIRS) * PAIR_W +: PAIR_W] <= wdata[PAIR_W-1:0];
        end
    end

    // Registered row read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_data <= '0;
        end else begin
            row_data <= rows[raddr];
        end
    end

endmodule

/* design/cost_ctrl.sv */
// Cost run sequencer
// Steps through row streaming and pipeline drain, then holds done until the next start

`timescale 1ns/1ps

module cost_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_start,
    input  luma_cost_pkg::cost_op_e cmd_op,
    input  logic                    row_last,
    output logic                    cnt_clear,
    output logic                    cnt_en,
    output logic                    acc_clear,
    output logic                    row_valid,
    output luma_cost_pkg::cost_op_e op,
    output logic                    busy,
    output logic                    done_flag
);

    luma_cost_pkg::ctrl_state_e state;
    luma_cost_pkg::ctrl_state_e state_nxt;
    logic [2:0]                 rv_pipe;
    logic                       start_ok;

    assign busy      = (state == luma_cost_pkg::st_run) || (state == luma_cost_pkg::st_drain);
    assign start_ok  = cmd_start && !busy;
    assign done_flag = (state == luma_cost_pkg::st_done);
    assign cnt_clear = start_ok;
    assign cnt_en    = (state == luma_cost_pkg::st_run);
    // Row data trails the row index by one buffer read
    assign row_valid = rv_pipe[0];
    // First valid row of a run zeroes the sum
    assign acc_clear = rv_pipe[0] && !rv_pipe[1];

    always_comb begin
        state_nxt = state;
        case (state)
            luma_cost_pkg::st_run:   if (row_last) state_nxt = luma_cost_pkg::st_drain;
            // Last row read, squared and summed
            luma_cost_pkg::st_drain: if (rv_pipe == 3'b100) state_nxt = luma_cost_pkg::st_done;
            default:                 if (start_ok) state_nxt = luma_cost_pkg::st_run;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= luma_cost_pkg::st_idle;
            op      <= luma_cost_pkg::op_sse_all;
            rv_pipe <= '0;
        end else begin
            state   <= state_nxt;
            rv_pipe <= {rv_pipe[1:0], cnt_en};
            if (start_ok) begin
                op <= cmd_op;
            end
        end
    end

endmodule

/* design/row_counter.sv */
// Row index counter with a last-row flag

`timescale 1ns/1ps

module row_counter #(
    parameter int BLOCK_SIZE = luma_cost_pkg::block_size
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clear,
    input  logic                          en,
    output logic [$clog2(BLOCK_SIZE)-1:0] row_idx,
    output logic                          row_last
);

    assign row_last = (row_idx == $clog2(BLOCK_SIZE)'(BLOCK_SIZE - 1));

    // Holds on the last row until cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_idx <= '0;
        end else if (clear) begin
            row_idx <= '0;
        end else if (en && !row_last) begin
            row_idx <= row_idx + 1'b1;
        end
    end

endmodule

/* design/sse_accum.sv */
// Pipelined sum-of-squares accumulator, one row per cycle
// Square, adder tree, then accumulate, with optional DC exclusion

`timescale 1ns/1ps

module sse_accum #(
    parameter int COEF_WIDTH = luma_cost_pkg::coef_width,
    parameter int BLOCK_SIZE = luma_cost_pkg::block_size,
    parameter int COST_WIDTH = luma_cost_pkg::cost_width
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clear,
    input  logic                             row_valid,
    input  logic                             row_first,
    input  luma_cost_pkg::cost_op_e          op,
    input  logic [BLOCK_SIZE*COEF_WIDTH-1:0] row_data,
    output logic [COST_WIDTH-1:0]            cost,
    output logic                             cost_valid
);

    localparam int SQ_W   = 2 * COEF_WIDTH;
    localparam int LEVELS = $clog2(BLOCK_SIZE);
    localparam int SUM_W  = SQ_W + LEVELS;

    logic signed [COEF_WIDTH-1:0] coef [BLOCK_SIZE];
    logic [SQ_W-1:0]              sq [BLOCK_SIZE];
    logic [SUM_W-1:0]             tree [LEVELS+1][BLOCK_SIZE];
    logic [SUM_W-1:0]             row_sum;
    logic                         sq_valid;
    logic                         sum_valid;

    always_comb begin
        for (int c = 0; c < BLOCK_SIZE; c++) begin
            coef[c] = row_data[c*COEF_WIDTH +: COEF_WIDTH];
        end
    end

    // ----------------------------------------
    // Stage one, squares
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (row_valid) begin
            for (int c = 0; c < BLOCK_SIZE; c++) begin
                sq[c] <= SQ_W'(coef[c] * coef[c]);
            end
            // DC sits at column 0 of the first row
            if (row_first && op == luma_cost_pkg::op_sse_ac) begin
                sq[0] <= '0;
            end
        end
    end

    // ----------------------------------------
    // Stage two, adder tree
    // ----------------------------------------
    always_comb begin
        tree = '{default: '0};
        for (int c = 0; c < BLOCK_SIZE; c++) begin
            tree[0][c] = SUM_W'(sq[c]);
        end
        for (int l = 0; l < LEVELS; l++) begin
            for (int n = 0; n < (BLOCK_SIZE >> (l + 1)); n++) begin
                tree[l+1][n] = tree[l][2*n] + tree[l][2*n+1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sq_valid) begin
            row_sum <= tree[LEVELS][0];
        end
    end

    // ----------------------------------------
    // Stage three, accumulate
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sq_valid   <= 1'b0;
            sum_valid  <= 1'b0;
            cost_valid <= 1'b0;
            cost       <= '0;
        end else begin
            sq_valid   <= row_valid;
            sum_valid  <= sq_valid;
            // Nothing behind the row sum now landing
            cost_valid <= sum_valid && !sq_valid;
            if (clear) begin
                cost <= '0;
            end else if (sum_valid) begin
                cost <= cost + COST_WIDTH'(row_sum);
            end
        end
    end

endmodule

/* design/luma_cost_top.sv */
// Luma transform-cost engine top level
// AXI4-Lite slave, coefficient buffer, sequencer, row counter and accumulator

`timescale 1ns/1ps

module luma_cost_top #(
    parameter int COEF_WIDTH = luma_cost_pkg::coef_width,
    parameter int BLOCK_SIZE = luma_cost_pkg::block_size,
    parameter int COST_WIDTH = luma_cost_pkg::cost_width
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [luma_cost_pkg::addr_width-1:0] awaddr,
    input  logic                                 wvalid,
    output logic                                 wready,
    input  logic [luma_cost_pkg::data_width-1:0] wdata,
    output logic                                 bvalid,
    input  logic                                 bready,
    output logic [1:0]                           bresp,
    input  logic                                 arvalid,
    output logic                                 arready,
    input  logic [luma_cost_pkg::addr_width-1:0] araddr,
    output logic                                 rvalid,
    input  logic                                 rready,
    output logic [luma_cost_pkg::data_width-1:0] rdata,
    output logic [1:0]                           rresp,
    output logic                                 done_irq
);

    logic                                         buf_we;
    logic [$clog2(luma_cost_pkg::coef_words)-1:0] buf_waddr;
    logic [luma_cost_pkg::data_width-1:0]         buf_wdata;
    logic                                         cmd_start;
    luma_cost_pkg::cost_op_e                      cmd_op;
    logic                                         cnt_clear;
    logic                                         cnt_en;
    logic [$clog2(BLOCK_SIZE)-1:0]                row_idx;
    logic                                         row_last;
    logic [BLOCK_SIZE*COEF_WIDTH-1:0]             row_data;
    logic                                         acc_clear;
    logic                                         row_valid;
    luma_cost_pkg::cost_op_e                      acc_op;
    logic                                         busy;
    logic                                         done_flag;
    logic [COST_WIDTH-1:0]                        cost;
    logic                                         cost_valid;

    assign done_irq = done_flag;

    axil_cost_regs regs_i (
        .clk, .rst_n,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .buf_we, .buf_waddr, .buf_wdata, .cmd_start, .cmd_op,
        .busy, .done_flag, .cost, .cost_valid
    );

    coef_row_buf #(.COEF_WIDTH(COEF_WIDTH), .BLOCK_SIZE(BLOCK_SIZE)) buf_i (
        .clk, .rst_n,
        .we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
        .raddr(row_idx), .row_data
    );

    cost_ctrl ctrl_i (
        .clk, .rst_n, .cmd_start, .cmd_op, .row_last,
        .cnt_clear, .cnt_en, .acc_clear, .row_valid,
        .op(acc_op), .busy, .done_flag
    );

    row_counter #(.BLOCK_SIZE(BLOCK_SIZE)) cnt_i (
        .clk, .rst_n, .clear(cnt_clear), .en(cnt_en), .row_idx, .row_last
    );

    // The clearing cycle is also the first row of the block
    sse_accum #(
        .COEF_WIDTH(COEF_WIDTH),
        .BLOCK_SIZE(BLOCK_SIZE),
        .COST_WIDTH(COST_WIDTH)
    ) acc_i (
        .clk, .rst_n,
        .clear(acc_clear), .row_valid, .row_first(acc_clear), .op(acc_op),
        .row_data, .cost, .cost_valid
    );

endmodule

/* bench/luma_cost_tb.sv */
// Testbench for the luma cost engine
// AXI4-Lite host tasks, a reference cost model and a watchdog

`timescale 1ns/1ps

module luma_cost_tb;

    localparam int coef_width = luma_cost_pkg::coef_width;
    localparam int block_size = luma_cost_pkg::block_size;
    localparam int cost_width = luma_cost_pkg::cost_width;
    localparam int num_coefs  = block_size * block_size;
    localparam int num_runs   = 4;
    localparam int watchdog_cycles = num_runs * (block_size + 20) + 128 * 10 + 2000;
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    logic        clk;
    logic        rst_n;
    logic        awvalid;
    logic        awready;
    logic [11:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [11:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        done_irq;

    logic signed [coef_width-1:0] coefs [num_coefs];
    logic [31:0]                  rng_state;
    logic [cost_width-1:0]        cost_all;

    luma_cost_top #(
        .COEF_WIDTH(coef_width),
        .BLOCK_SIZE(block_size),
        .COST_WIDTH(cost_width)
    ) dut_i (
        .clk, .rst_n,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .done_irq
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("tests failed");
        $fatal(1);
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Reference sum of squares, DC optionally left out
    function automatic logic [cost_width-1:0] model_cost(input logic skip_dc);
        logic [63:0] acc;
        acc = '0;
        for (int n = 0; n < num_coefs; n++) begin
            if (!(skip_dc && n == 0)) begin
                acc = acc + 64'(longint'(coefs[n]) * longint'(coefs[n]));
            end
        end
        return acc[cost_width-1:0];
    endfunction

    // ----------------------------------------
    // AXI4-Lite host
    // ----------------------------------------
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              input int stall, output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (stall == 0);
        @(negedge clk);
        while (!awready) @(negedge clk);
        assert (wready) else report_error("wready not raised together with awready");
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            assert (bvalid && bresp == resp)
                else report_error("write response changed while bready was low");
        end
        if (stall > 0) begin
            @(posedge clk);
            #1;
            bready = 1'b1;
        end
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, input int stall,
                             output logic [31:0] data, output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (stall == 0);
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            assert (rvalid && rdata == data && rresp == resp)
                else report_error("read data changed while rready was low");
        end
        if (stall > 0) begin
            @(posedge clk);
            #1;
            rready = 1'b1;
        end
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic write_ok(input logic [11:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, 0, resp);
        assert (resp == resp_okay)
            else report_error($sformatf("write to %h answered %b", addr, resp));
    endtask

    task automatic read_ok(input logic [11:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axil_read(addr, 0, data, resp);
        assert (resp == resp_okay)
            else report_error($sformatf("read of %h answered %b", addr, resp));
    endtask

    task automatic write_block;
        for (int k = 0; k < num_coefs / 2; k++) begin
            write_ok(luma_cost_pkg::coef_base + 12'(4 * k), {coefs[2*k+1], coefs[2*k]});
        end
    endtask

    task automatic start_run(input luma_cost_pkg::cost_op_e op);
        write_ok(luma_cost_pkg::reg_ctrl, {30'b0, op, 1'b1});
    endtask

    task automatic wait_done;
        logic [31:0] status;
        status = '0;
        while (!status[1]) read_ok(luma_cost_pkg::reg_status, status);
    endtask

    task automatic check_cost(input logic [cost_width-1:0] exp, input string what,
                              output logic [cost_width-1:0] got);
        logic [31:0] lo;
        logic [31:0] hi;
        read_ok(luma_cost_pkg::reg_cost_lo, lo);
        read_ok(luma_cost_pkg::reg_cost_hi, hi);
        assert ((hi >> (cost_width - 32)) == 0)
            else report_error($sformatf("COST_HI %h is not zero-extended", hi));
        got = {hi[cost_width-33:0], lo};
        assert (got == exp)
            else report_error($sformatf("%s cost %h, expected %h", what, got, exp));
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0]           rd;
        logic [1:0]            resp;
        logic [cost_width-1:0] got;
        logic [cost_width-1:0] exp_cost;

        rst_n     = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        rng_state = 32'h999d_8b4f;
        repeat (2) @(posedge clk);
        #1;
        assert (!awready && !wready && !arready && !bvalid && !rvalid && !done_irq)
            else report_error("handshake or done outputs high during reset");
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // Idle state after reset
        read_ok(luma_cost_pkg::reg_status, rd);
        assert (rd == 32'h0) else report_error($sformatf("STATUS %h after reset", rd));
        check_cost('0, "reset", got);
        assert (!done_irq) else report_error("done_irq high after reset");

        // Random block, full sum of squares
        for (int n = 0; n < num_coefs; n++) begin
            rng_state = lcg_next(rng_state);
            coefs[n]  = rng_state[31:16];
        end
        write_block();
        start_run(luma_cost_pkg::op_sse_all);
        wait_done();
        assert (done_irq) else report_error("done_irq low after a finished run");
        check_cost(model_cost(1'b0), "random all", cost_all);
        read_ok(luma_cost_pkg::reg_status, rd);
        assert (!rd[1]) else report_error("STATUS done bit not cleared by the read");

        // Same block without DC
        start_run(luma_cost_pkg::op_sse_ac);
        wait_done();
        check_cost(model_cost(1'b1), "random ac", got);
        assert (got == cost_all - cost_width'(longint'(coefs[0]) * longint'(coefs[0])))
            else report_error("AC cost is not the full cost minus the DC square");

        // Most negative coefficients push the cost above 32 bits
        for (int n = 0; n < num_coefs; n++) coefs[n] = 16'sh8000;
        write_block();
        start_run(luma_cost_pkg::op_sse_all);
        wait_done();
        check_cost(model_cost(1'b0), "full scale", got);
        assert (got == (cost_width'(num_coefs) << 30))
            else report_error("full scale cost is not 256 times 2^30");

        // Start and coefficient writes while busy
        // The last word is read late in the run, so a kept write would show
        start_run(luma_cost_pkg::op_sse_all);
        axil_write(luma_cost_pkg::reg_ctrl, 32'h3, 0, resp);
        assert (resp == resp_slverr) else report_error("start while busy not answered SLVERR");
        axil_write(luma_cost_pkg::coef_base + 12'(4 * (num_coefs / 2 - 1)), 32'h0001_0001,
                   0, resp);
        assert (resp == resp_slverr)
            else report_error("coefficient write while busy not answered SLVERR");
        wait_done();
        exp_cost = model_cost(1'b0);
        check_cost(exp_cost, "busy run", got);

        // Unmapped offset
        axil_read(12'h010, 0, rd, resp);
        assert (resp == resp_slverr) else report_error("unmapped read not answered SLVERR");
        axil_write(12'h010, 32'h0, 0, resp);
        assert (resp == resp_slverr) else report_error("unmapped write not answered SLVERR");

        // Host back-pressure on both response channels
        axil_write(luma_cost_pkg::reg_ctrl, 32'h0, 6, resp);
        assert (resp == resp_okay) else report_error("CTRL write without start not OKAY");
        axil_read(luma_cost_pkg::reg_cost_hi, 6, rd, resp);
        assert (resp == resp_okay && rd == 32'(exp_cost[cost_width-1:32]))
            else report_error($sformatf("stalled COST_HI read gave %h", rd));

        $display("all tests passed");
        $finish;
    end

endmodule

/* luma_cost.f */
design/luma_cost_pkg.sv
design/axil_cost_regs.sv
design/coef_row_buf.sv
design/cost_ctrl.sv
design/row_counter.sv
design/sse_accum.sv
design/luma_cost_top.sv
bench/luma_cost_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the luma cost testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f luma_cost.f \
    --top-module luma_cost_tb -o luma_cost_sim &&
./obj_dir/luma_cost_sim | tee /dev/stderr | grep -q "^all tests passed$" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
